/* common/agen_pkg.sv */
`default_nettype none

// widths shared by the range generators, the 2D chain and the register block.
package agen_pkg;

   // addresses, the row base and both strides are this wide.
   // all address arithmetic wraps modulo 2**ADDR_W.
   localparam int ADDR_W = 16;

   // row and column item counts.
   // a count of zero is not a valid job setting.
   localparam int COUNT_W = 8;

endpackage : agen_pkg

`default_nettype wire

/* common/agen_regs_pkg.sv */
`default_nettype none

// register map of the job settings block.
package agen_regs_pkg;

   localparam int REG_ADDR_W = 3;

   // the first five entries are data registers.
   // any write to REG_CTRL starts a job.
   typedef enum logic [REG_ADDR_W-1:0] {
      REG_ROW_BASE   = 3'd0,
      REG_ROW_STRIDE = 3'd1,
      REG_ROW_COUNT  = 3'd2,
      REG_COL_STRIDE = 3'd3,
      REG_COL_COUNT  = 3'd4,
      REG_CTRL       = 3'd5
   } agen_reg_e;

endpackage : agen_regs_pkg

`default_nettype wire

/* design/agen_2d.sv */
`timescale 1ns/10ps
`default_nettype none

// two chained range generators.
// every row start address from the row generator is the base of one full column
// range. The row item is only taken once its column range has ended, so job_done
// comes up in the same cycle as the last address transfer.
module agen_2d (
   input  logic                         clk,
   input  logic                         rst_n,

   input  logic                         run,
   output logic                         job_done,
   input  logic [agen_pkg::ADDR_W-1:0]  row_base,
   input  logic [agen_pkg::ADDR_W-1:0]  row_stride,
   input  logic [agen_pkg::COUNT_W-1:0] row_count,
   input  logic [agen_pkg::ADDR_W-1:0]  col_stride,
   input  logic [agen_pkg::COUNT_W-1:0] col_count,

   output logic                         addr_valid,
   input  logic                         addr_ready,
   output logic [agen_pkg::ADDR_W-1:0]  addr,
   output logic                         addr_last
);

   import agen_pkg::*;

   logic              row_valid;
   logic [ADDR_W-1:0] row_addr;
   logic              row_eot;
   logic              col_cfg_ready;
   logic              col_eot;

   // row starts only ever step forwards.
   rng #(
      .signed_mode (1'b0)
   ) row_rng_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg_valid  (run),
      .cfg_ready  (job_done),
      .cfg_base   (row_base),
      .cfg_stride (row_stride),
      .cfg_count  (row_count),
      .dout_valid (row_valid),
      .dout_ready (col_cfg_ready),
      .dout_data  (row_addr),
      .dout_eot   (row_eot)
   );

   // the column stride may be negative to walk a row backwards.
   rng #(
      .signed_mode (1'b1)
   ) col_rng_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg_valid  (row_valid),
      .cfg_ready  (col_cfg_ready),
      .cfg_base   (row_addr),
      .cfg_stride (col_stride),
      .cfg_count  (col_count),
      .dout_valid (addr_valid),
      .dout_ready (addr_ready),
      .dout_data  (addr),
      .dout_eot   (col_eot)
   );

   // last column of the last row.
   assign addr_last = col_eot & row_eot;

endmodule : agen_2d

`default_nettype wire

/* design/agen_regs.sv */
`timescale 1ns/10ps
`default_nettype none

// job settings registers with a start command.
// writes are single cycle strobes and are dropped while a job is running, so the
// settings stay stable for the whole job.
module agen_regs (
   input  logic                            clk,
   input  logic                            rst_n,

   input  logic                            reg_wr_en,
   input  logic [agen_regs_pkg::REG_ADDR_W-1:0] reg_addr,
   input  logic [agen_pkg::ADDR_W-1:0]     reg_wdata,

   input  logic                            job_done,

   output logic [agen_pkg::ADDR_W-1:0]     row_base,
   output logic [agen_pkg::ADDR_W-1:0]     row_stride,
   output logic [agen_pkg::ADDR_W-1:0]     col_stride,
   output logic [agen_pkg::COUNT_W-1:0]    row_count,
   output logic [agen_pkg::COUNT_W-1:0]    col_count,
   output logic                            run,
   output logic                            busy
);

   import agen_pkg::*;
   import agen_regs_pkg::*;

   agen_reg_e reg_sel;
   logic      wr_idle;

   assign reg_sel = agen_reg_e'(reg_addr);

   // only writes issued while idle take effect.
   assign wr_idle = reg_wr_en & ~run;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         row_base   <= '0;
         row_stride <= '0;
         row_count  <= '0;
         col_stride <= '0;
         col_count  <= '0;
      end else if (wr_idle) begin
         case (reg_sel)
            REG_ROW_BASE:   row_base   <= reg_wdata;
            REG_ROW_STRIDE: row_stride <= reg_wdata;
            REG_ROW_COUNT:  row_count  <= reg_wdata[COUNT_W-1:0];
            REG_COL_STRIDE: col_stride <= reg_wdata;
            REG_COL_COUNT:  col_count  <= reg_wdata[COUNT_W-1:0];
            default: ;
         endcase
      end
   end

   // run is set by a write to the control register.
   // it drops after the transfer that ends the job.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run <= 1'b0;
      end else if (job_done) begin
         run <= 1'b0;
      end else if (wr_idle && (reg_sel == REG_CTRL)) begin
         run <= 1'b1;
      end
   end

   assign busy = run;

endmodule : agen_regs

`default_nettype wire

/* design/agen_top.sv */
`timescale 1ns/10ps
`default_nettype none

// top level of the 2D address generator.
// the register block holds the job, the generator streams its addresses.
module agen_top (
   input  logic                                 clk,
   input  logic                                 rst_n,

   input  logic                                 reg_wr_en,
   input  logic [agen_regs_pkg::REG_ADDR_W-1:0] reg_addr,
   input  logic [agen_pkg::ADDR_W-1:0]          reg_wdata,
   output logic                                 busy,

   output logic                                 addr_valid,
   input  logic                                 addr_ready,
   output logic [agen_pkg::ADDR_W-1:0]          addr,
   output logic                                 addr_last
);

   import agen_pkg::*;

   logic [ADDR_W-1:0]  row_base;
   logic [ADDR_W-1:0]  row_stride;
   logic [ADDR_W-1:0]  col_stride;
   logic [COUNT_W-1:0] row_count;
   logic [COUNT_W-1:0] col_count;
   logic               run;
   logic               job_done;

   agen_regs regs_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .reg_wr_en  (reg_wr_en),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .job_done   (job_done),
      .row_base   (row_base),
      .row_stride (row_stride),
      .col_stride (col_stride),
      .row_count  (row_count),
      .col_count  (col_count),
      .run        (run),
      .busy       (busy)
   );

   agen_2d gen_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .job_done   (job_done),
      .row_base   (row_base),
      .row_stride (row_stride),
      .row_count  (row_count),
      .col_stride (col_stride),
      .col_count  (col_count),
      .addr_valid (addr_valid),
      .addr_ready (addr_ready),
      .addr       (addr),
      .addr_last  (addr_last)
   );

endmodule : agen_top

`default_nettype wire

/* project.f */
common/agen_pkg.sv
common/agen_regs_pkg.sv
rng/rng.sv
design/agen_2d.sv
design/agen_regs.sv
design/agen_top.sv
test/tb_agen_top.sv

/* rng/rng.sv */
`timescale 1ns/10ps
`default_nettype none

// range generator.
// it emits base, base + stride, base + 2*stride and so on, cfg_count items in all,
// and flags the last item with dout_eot. The output is combinational from the
// config and the index register, so dout_valid simply follows cfg_valid.
module rng #(
   parameter bit signed_mode = 1'b0
) (
   input  logic                         clk,
   input  logic                         rst_n,

   input  logic                         cfg_valid,
   output logic                         cfg_ready,
   input  logic [agen_pkg::ADDR_W-1:0]  cfg_base,
   input  logic [agen_pkg::ADDR_W-1:0]  cfg_stride,
   input  logic [agen_pkg::COUNT_W-1:0] cfg_count,

   output logic                         dout_valid,
   input  logic                         dout_ready,
   output logic [agen_pkg::ADDR_W-1:0]  dout_data,
   output logic                         dout_eot
);

   import agen_pkg::*;

   logic [COUNT_W-1:0]        idx;
   logic [COUNT_W-1:0]        idx_next;
   logic                      xfer;

   // the product is formed at full width before it is cut back to ADDR_W.
   logic [ADDR_W+COUNT_W-1:0] stride_ext;
   logic [ADDR_W+COUNT_W-1:0] idx_ext;
   logic [ADDR_W+COUNT_W-1:0] offset;

   assign xfer = cfg_valid & dout_ready;

   assign idx_next = idx + 1'b1;

   // the range ends on the item whose successor index reaches the count.
   assign dout_eot = (idx_next == cfg_count);

   // the config is consumed together with its last output item.
   assign cfg_ready = dout_eot & xfer;

   assign dout_valid = cfg_valid;

   // a signed stride is sign extended so that a negative step walks downwards.
   assign stride_ext = signed_mode ? {{COUNT_W{cfg_stride[ADDR_W-1]}}, cfg_stride}
                                   : {{COUNT_W{1'b0}}, cfg_stride};

   assign idx_ext = {{ADDR_W{1'b0}}, idx};

   assign offset = idx_ext * stride_ext;

   // the sum keeps only the low ADDR_W bits and so wraps like the address space.
   assign dout_data = cfg_base + offset[ADDR_W-1:0];

   // the index moves one step per output transfer.
   // it goes back to zero when the last item is taken.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idx <= '0;
      end else if (xfer) begin
         if (dout_eot) begin
            idx <= '0;
         end else begin
            idx <= idx_next;
         end
      end
   end

endmodule : rng

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
   --top-module tb_agen_top \
   -f project.f \
   --Mdir obj_dir \
   -o tb_agen_top
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_agen_top
status=$?
if [ $status -ne 0 ]; then
   echo "simulation ended with status $status"
   exit 1
fi

exit 0

/* test/tb_agen_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_agen_top;

   import agen_pkg::*;
   import agen_regs_pkg::*;

   typedef struct packed {
      logic [ADDR_W-1:0]  row_base;
      logic [ADDR_W-1:0]  row_stride;
      logic [COUNT_W-1:0] row_count;
      logic [ADDR_W-1:0]  col_stride;
      logic [COUNT_W-1:0] col_count;
      logic               back_pressure;
   } job_t;

   localparam int NUM_JOBS = 7;

   // row_base, row_stride, row_count, col_stride, col_count, back-pressure.
   localparam job_t JOBS [NUM_JOBS] = '{
      '{16'h1000, 16'h0100, 8'd4, 16'h0004, 8'd5, 1'b0},
      '{16'hfff0, 16'h0010, 8'd3, 16'hfffe, 8'd6, 1'b0},   // wraps past the top
      '{16'h2000, 16'h0040, 8'd5, 16'h0008, 8'd4, 1'b1},
      '{16'h0004, 16'h8000, 8'd3, 16'hfffc, 8'd3, 1'b1},
      '{16'h1234, 16'h0010, 8'd1, 16'h0001, 8'd1, 1'b0},
      '{16'h4000, 16'h0200, 8'd1, 16'h0002, 8'd7, 1'b0},
      '{16'h0100, 16'h0020, 8'd2, 16'hfff0, 8'd9, 1'b1}
   };

   logic                  clk;
   logic                  rst_n;
   logic                  reg_wr_en;
   logic [REG_ADDR_W-1:0] reg_addr;
   logic [ADDR_W-1:0]     reg_wdata;
   logic                  busy;
   logic                  addr_valid;
   logic                  addr_ready;
   logic [ADDR_W-1:0]     addr;
   logic                  addr_last;
   integer                seed = 32'h9fde;

   agen_top dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .reg_wr_en  (reg_wr_en),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .busy       (busy),
      .addr_valid (addr_valid),
      .addr_ready (addr_ready),
      .addr       (addr),
      .addr_last  (addr_last)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      if (exp_val !== act_val) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp_val, act_val);
         $display("test failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   // address of row r, column c, with the column stride taken as signed.
   function automatic logic [ADDR_W-1:0] model_addr(input job_t job, input int r, input int c);
      int base;
      int rstride;
      int cstride;
      int sum;
      base = job.row_base;
      rstride = job.row_stride;
      cstride = $signed(job.col_stride);
      sum = base + r * rstride + c * cstride;
      return sum[ADDR_W-1:0];
   endfunction

   task automatic drive_write(input agen_reg_e sel, input logic [ADDR_W-1:0] data);
      reg_wr_en = 1'b1;
      reg_addr = sel;
      reg_wdata = data;
   endtask

   task automatic write_reg(input agen_reg_e sel, input logic [ADDR_W-1:0] data);
      @(negedge clk);
      drive_write(sel, data);
   endtask

   // streams one job and compares every transfer with the model.
   task automatic run_job(input int j);
      job_t              job;
      logic [ADDR_W-1:0] exp_q [$];
      logic [ADDR_W-1:0] exp_addr;
      logic [ADDR_W-1:0] held_addr;
      logic              held_last;
      logic [31:0]       rnd;
      logic              busy_now;
      bit                stall;
      bit                done;
      int                n;
      int                idx;
      int                cyc;
      job = JOBS[j];
      n = int'(job.row_count) * int'(job.col_count);
      for (int r = 0; r < int'(job.row_count); r++) begin
         for (int c = 0; c < int'(job.col_count); c++) begin
            exp_q.push_back(model_addr(job, r, c));
         end
      end
      write_reg(REG_ROW_BASE, job.row_base);
      write_reg(REG_ROW_STRIDE, job.row_stride);
      write_reg(REG_ROW_COUNT, 16'(job.row_count));
      write_reg(REG_COL_STRIDE, job.col_stride);
      write_reg(REG_COL_COUNT, 16'(job.col_count));
      write_reg(REG_CTRL, 16'h0001);
      idx = 0;
      cyc = 0;
      stall = 1'b0;
      done = 1'b0;
      held_addr = '0;
      held_last = 1'b0;
      while (!done) begin
         @(negedge clk);
         busy_now = busy;
         rnd = $random(seed);
         addr_ready = job.back_pressure ? rnd[0] : 1'b1;
         // other settings written during the job must be dropped.
         if (busy_now && cyc < 6) begin
            case (cyc)
               0: drive_write(REG_ROW_BASE, ~job.row_base);
               1: drive_write(REG_ROW_STRIDE, ~job.row_stride);
               2: drive_write(REG_ROW_COUNT, 16'(~job.row_count));
               3: drive_write(REG_COL_STRIDE, ~job.col_stride);
               4: drive_write(REG_COL_COUNT, 16'(~job.col_count));
               default: drive_write(REG_CTRL, 16'h0001);
            endcase
         end else begin
            reg_wr_en = 1'b0;
         end
         #1;
         if (cyc == 0) begin
            check_value($sformatf("job %0d busy at start", j), 32'd1, 32'(busy));
         end
         check_value($sformatf("job %0d valid", j), 32'd1, 32'(addr_valid));
         if (stall) begin
            check_value($sformatf("job %0d held addr", j), 32'(held_addr), 32'(addr));
            check_value($sformatf("job %0d held last", j), 32'(held_last), 32'(addr_last));
         end
         if (addr_valid && addr_ready) begin
            exp_addr = exp_q.pop_front();
            check_value($sformatf("job %0d addr %0d", j, idx), 32'(exp_addr), 32'(addr));
            check_value($sformatf("job %0d last %0d", j, idx), 32'(idx == n - 1),
                        32'(addr_last));
            idx++;
            done = (idx == n);
            stall = 1'b0;
         end else begin
            stall = addr_valid;
            held_addr = addr;
            held_last = addr_last;
         end
         cyc++;
      end
      @(negedge clk);
      reg_wr_en = 1'b0;
      addr_ready = 1'b1;
      #1;
      check_value($sformatf("job %0d busy after end", j), 32'd0, 32'(busy));
      check_value($sformatf("job %0d valid after end", j), 32'd0, 32'(addr_valid));
   endtask

   // the limit allows 20 cycles for each address in the table plus a fixed margin.
   initial begin : watchdog
      int limit;
      limit = 200;
      for (int j = 0; j < NUM_JOBS; j++) begin
         limit += 20 * int'(JOBS[j].row_count) * int'(JOBS[j].col_count);
      end
      repeat (limit) @(posedge clk);
      $display("timeout, the jobs did not finish within %0d cycles", limit);
      $display("test failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      rst_n = 1'b0;
      reg_wr_en = 1'b0;
      reg_addr = '0;
      reg_wdata = '0;
      addr_ready = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      #1;
      check_value("reset busy", 32'd0, 32'(busy));
      check_value("reset valid", 32'd0, 32'(addr_valid));
      for (int j = 0; j < NUM_JOBS; j++) begin
         run_job(j);
      end
      $display("test passed");
      $finish;
   end

endmodule : tb_agen_top

`default_nettype wire
